// ==== rtl/wired_pkg.sv ====
`default_nettype none

package wired_pkg;

  localparam int XLEN       = 32;
  localparam int ARCH_REGS  = 32;
  localparam int ARCH_ID_W  = 5;
  localparam int ROB_DEPTH  = 8;
  localparam int ROB_ID_W   = 3;
  localparam int MUL_STAGES = 3;

  typedef logic [ARCH_ID_W-1:0] arch_id_t;
  typedef logic [ROB_ID_W-1:0]  rob_id_t;
  typedef logic [XLEN-1:0]      data_t;

  // alu ops first, mul routed to the multiplier
  typedef enum logic [2:0] {
    OP_ADD = 3'd0,
    OP_SUB = 3'd1,
    OP_AND = 3'd2,
    OP_OR  = 3'd3,
    OP_XOR = 3'd4,
    OP_SLL = 3'd5,
    OP_MUL = 3'd6
  } op_t;

endpackage

`default_nettype wire

// ==== rtl/wired_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module wired_regfile (
  input  wire logic                 clk,
  input  wire logic                 rst_n,
  input  wire wired_pkg::arch_id_t  raddr_i [2],
  output wired_pkg::data_t          rdata_o [2],
  input  wire logic                 we_i,
  input  wire wired_pkg::arch_id_t  waddr_i,
  input  wire wired_pkg::data_t     wdata_i
);

  wired_pkg::data_t regs_q [wired_pkg::ARCH_REGS];
  logic wr_en;

  assign wr_en = we_i && (waddr_i != '0); // r0 stays zero

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < wired_pkg::ARCH_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_en) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // write-to-read bypass
  always_comb begin
    for (int i = 0; i < 2; i++) begin
      if (raddr_i[i] == '0) rdata_o[i] = '0;
      else if (wr_en && waddr_i == raddr_i[i]) rdata_o[i] = wdata_i;
      else rdata_o[i] = regs_q[raddr_i[i]];
    end
  end

endmodule

`default_nettype wire

// ==== rtl/wired_rename.sv ====
`timescale 1ns/1ps
`default_nettype none

module wired_rename (
  input  wire logic                 clk,
  input  wire logic                 rst_n,
  input  wire logic                 inst_valid_i,
  output logic                      inst_ready_o,
  input  wire wired_pkg::op_t       inst_op_i,
  input  wire wired_pkg::arch_id_t  inst_rd_i,
  input  wire wired_pkg::arch_id_t  inst_rs1_i,
  input  wire wired_pkg::arch_id_t  inst_rs2_i,
  input  wire wired_pkg::data_t     inst_imm_i,
  input  wire logic                 inst_use_imm_i,
  output wired_pkg::arch_id_t       rf_raddr_o [2],
  input  wire wired_pkg::data_t     rf_rdata_i [2],
  input  wire logic                 rob_full_i,
  input  wire wired_pkg::rob_id_t   rob_tail_i,
  output logic                      alloc_o,
  input  wire logic                 dispatch_ready_i,
  output logic                      ren_valid_o,
  output wired_pkg::op_t            ren_op_o,
  output wired_pkg::arch_id_t       ren_rd_o,
  output wired_pkg::rob_id_t        ren_rob_id_o,
  output logic                      ren_src_ready_o [2],
  output wired_pkg::data_t          ren_src_data_o [2],
  output wired_pkg::rob_id_t        ren_src_rob_id_o [2],
  input  wire logic                 commit_valid_i,
  input  wire wired_pkg::rob_id_t   commit_rob_id_i,
  input  wire wired_pkg::arch_id_t  commit_rd_i
);

  logic                pend_q [wired_pkg::ARCH_REGS];
  wired_pkg::rob_id_t  id_q   [wired_pkg::ARCH_REGS];
  logic                accept;
  logic                commit_hit [2];
  logic                clear_en;

  assign inst_ready_o = !rob_full_i && dispatch_ready_i;
  assign accept       = inst_valid_i && inst_ready_o;
  assign alloc_o      = accept;
  assign ren_valid_o  = accept;
  assign ren_op_o     = inst_op_i;
  assign ren_rd_o     = inst_rd_i;
  assign ren_rob_id_o = rob_tail_i;

  assign rf_raddr_o[0] = inst_rs1_i;
  assign rf_raddr_o[1] = inst_rs2_i;

  // only the latest producer of a register clears its entry
  assign clear_en = commit_valid_i && (id_q[commit_rd_i] == commit_rob_id_i);

  always_comb begin
    for (int i = 0; i < 2; i++) begin
      commit_hit[i] = clear_en && (commit_rd_i == rf_raddr_o[i]);
      // a source retiring this cycle reads the regfile bypass
      ren_src_ready_o[i]  = !pend_q[rf_raddr_o[i]] || commit_hit[i] || (rf_raddr_o[i] == '0);
      ren_src_data_o[i]   = rf_rdata_i[i];
      ren_src_rob_id_o[i] = id_q[rf_raddr_o[i]];
    end
    if (inst_use_imm_i) begin
      ren_src_ready_o[0] = 1'b1;
      ren_src_data_o[0]  = inst_imm_i;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int r = 0; r < wired_pkg::ARCH_REGS; r++) begin
        pend_q[r] <= 1'b0;
      end
    end else begin
      if (clear_en) pend_q[commit_rd_i] <= 1'b0;
      if (accept && inst_rd_i != '0) pend_q[inst_rd_i] <= 1'b1; // new producer wins
    end
  end

  always_ff @(posedge clk) begin
    if (accept && inst_rd_i != '0) begin
      id_q[inst_rd_i] <= rob_tail_i;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/wired_dispatch.sv ====
`timescale 1ns/1ps
`default_nettype none

module wired_dispatch (
  input  wire logic                clk,
  input  wire logic                rst_n,
  input  wire logic                ren_valid_i,
  input  wire wired_pkg::op_t      ren_op_i,
  input  wire wired_pkg::rob_id_t  ren_rob_id_i,
  input  wire logic                ren_src_ready_i [2],
  input  wire wired_pkg::data_t    ren_src_data_i [2],
  input  wire wired_pkg::rob_id_t  ren_src_rob_id_i [2],
  output logic                     dispatch_ready_o,
  output wired_pkg::rob_id_t       rob_rd_id_o [2],
  input  wire logic                rob_rd_done_i [2],
  input  wire wired_pkg::data_t    rob_rd_data_i [2],
  input  wire logic                cdb_valid_i,
  input  wire wired_pkg::rob_id_t  cdb_rob_id_i,
  input  wire wired_pkg::data_t    cdb_data_i,
  input  wire logic                alu_busy_i,
  output logic                     alu_valid_o,
  output logic                     mul_valid_o,
  output wired_pkg::op_t           ex_op_o,
  output wired_pkg::data_t         ex_a_o,
  output wired_pkg::data_t         ex_b_o,
  output wired_pkg::rob_id_t       ex_rob_id_o
);

  logic                valid_q;
  wired_pkg::op_t      op_q;
  wired_pkg::rob_id_t  rob_id_q;
  logic                rdy_q    [2];
  wired_pkg::data_t    data_q   [2];
  wired_pkg::rob_id_t  src_id_q [2];
  logic                is_mul;
  logic                issue;

  assign is_mul = (op_q == wired_pkg::OP_MUL);
  assign issue  = valid_q && rdy_q[0] && rdy_q[1] && (is_mul || !alu_busy_i);

  assign dispatch_ready_o = !valid_q || issue;
  assign alu_valid_o      = issue && !is_mul;
  assign mul_valid_o      = issue && is_mul;
  assign ex_op_o          = op_q;
  assign ex_a_o           = data_q[0];
  assign ex_b_o           = data_q[1];
  assign ex_rob_id_o      = rob_id_q;

  assign rob_rd_id_o[0] = src_id_q[0];
  assign rob_rd_id_o[1] = src_id_q[1];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (ren_valid_i) begin
      valid_q <= 1'b1;
    end else if (issue) begin
      valid_q <= 1'b0;
    end
  end

  // captured operands issue a cycle later
  always_ff @(posedge clk) begin
    if (ren_valid_i) begin
      op_q     <= ren_op_i;
      rob_id_q <= ren_rob_id_i;
      for (int i = 0; i < 2; i++) begin
        rdy_q[i]    <= ren_src_ready_i[i];
        data_q[i]   <= ren_src_data_i[i];
        src_id_q[i] <= ren_src_rob_id_i[i];
      end
    end else begin
      for (int i = 0; i < 2; i++) begin
        if (!rdy_q[i] && cdb_valid_i && cdb_rob_id_i == src_id_q[i]) begin
          rdy_q[i]  <= 1'b1;
          data_q[i] <= cdb_data_i;
        end else if (!rdy_q[i] && rob_rd_done_i[i]) begin
          rdy_q[i]  <= 1'b1;
          data_q[i] <= rob_rd_data_i[i];
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/wired_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module wired_alu (
  input  wire logic                clk,
  input  wire logic                rst_n,
  input  wire logic                valid_i,
  input  wire wired_pkg::op_t      op_i,
  input  wire wired_pkg::data_t    a_i,
  input  wire wired_pkg::data_t    b_i,
  input  wire wired_pkg::rob_id_t  rob_id_i,
  output logic                     busy_o,
  output logic                     req_o,
  input  wire logic                grant_i,
  output wired_pkg::rob_id_t       rob_id_o,
  output wired_pkg::data_t         data_o
);

  wired_pkg::data_t result;
  logic req_q;

  always_comb begin
    case (op_i)
      wired_pkg::OP_ADD: result = a_i + b_i;
      wired_pkg::OP_SUB: result = a_i - b_i;
      wired_pkg::OP_AND: result = a_i & b_i;
      wired_pkg::OP_OR:  result = a_i | b_i;
      wired_pkg::OP_XOR: result = a_i ^ b_i;
      wired_pkg::OP_SLL: result = a_i << b_i[4:0];
      default:           result = '0;
    endcase
  end

  // free again in the cycle the held result is granted
  assign busy_o = req_q && !grant_i;
  assign req_o  = req_q;

  always_ff @(posedge clk) begin
    if (!rst_n) req_q <= 1'b0;
    else if (valid_i) req_q <= 1'b1;
    else if (grant_i) req_q <= 1'b0;
  end

  always_ff @(posedge clk) begin
    if (valid_i) begin
      rob_id_o <= rob_id_i;
      data_o   <= result;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/wired_muler.sv ====
`timescale 1ns/1ps
`default_nettype none

module wired_muler (
  input  wire logic                clk,
  input  wire logic                rst_n,
  input  wire logic                valid_i,
  input  wire wired_pkg::data_t    a_i,
  input  wire wired_pkg::data_t    b_i,
  input  wire wired_pkg::rob_id_t  rob_id_i,
  output logic                     valid_o,
  output wired_pkg::rob_id_t       rob_id_o,
  output wired_pkg::data_t         data_o
);

  localparam int N = wired_pkg::MUL_STAGES;

  logic                vld_q  [N];
  wired_pkg::rob_id_t  id_q   [N];
  wired_pkg::data_t    prod_q [N];
  wired_pkg::data_t    product;

  assign product = a_i * b_i; // low word only

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int s = 0; s < N; s++) begin
        vld_q[s] <= 1'b0;
      end
    end else begin
      vld_q[0] <= valid_i;
      for (int s = 1; s < N; s++) begin
        vld_q[s] <= vld_q[s-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    id_q[0]   <= rob_id_i;
    prod_q[0] <= product;
    for (int s = 1; s < N; s++) begin
      id_q[s]   <= id_q[s-1];
      prod_q[s] <= prod_q[s-1];
    end
  end

  assign valid_o  = vld_q[N-1];
  assign rob_id_o = id_q[N-1];
  assign data_o   = prod_q[N-1];

endmodule

`default_nettype wire

// ==== rtl/wired_cdb_arb.sv ====
`timescale 1ns/1ps
`default_nettype none

module wired_cdb_arb (
  input  wire logic                clk,
  input  wire logic                rst_n,
  input  wire logic                alu_req_i,
  input  wire wired_pkg::rob_id_t  alu_rob_id_i,
  input  wire wired_pkg::data_t    alu_data_i,
  output logic                     alu_grant_o,
  input  wire logic                mul_valid_i,
  input  wire wired_pkg::rob_id_t  mul_rob_id_i,
  input  wire wired_pkg::data_t    mul_data_i,
  output logic                     cdb_valid_o,
  output wired_pkg::rob_id_t       cdb_rob_id_o,
  output wired_pkg::data_t         cdb_data_o
);

  // multiplier cannot stall, so it always wins
  assign alu_grant_o = alu_req_i && !mul_valid_i;

  always_ff @(posedge clk) begin
    if (!rst_n) cdb_valid_o <= 1'b0;
    else cdb_valid_o <= mul_valid_i || alu_req_i;
  end

  always_ff @(posedge clk) begin
    cdb_rob_id_o <= mul_valid_i ? mul_rob_id_i : alu_rob_id_i;
    cdb_data_o   <= mul_valid_i ? mul_data_i : alu_data_i;
  end

endmodule

`default_nettype wire

// ==== rtl/wired_rob.sv ====
`timescale 1ns/1ps
`default_nettype none

module wired_rob (
  input  wire logic                 clk,
  input  wire logic                 rst_n,
  input  wire logic                 alloc_i,
  input  wire wired_pkg::arch_id_t  alloc_rd_i,
  output wired_pkg::rob_id_t        tail_o,
  output logic                      full_o,
  input  wire wired_pkg::rob_id_t   rd_id_i [2],
  output logic                      rd_done_o [2],
  output wired_pkg::data_t          rd_data_o [2],
  input  wire logic                 cdb_valid_i,
  input  wire wired_pkg::rob_id_t   cdb_rob_id_i,
  input  wire wired_pkg::data_t     cdb_data_i,
  output logic                      commit_valid_o,
  output wired_pkg::rob_id_t        commit_rob_id_o,
  output wired_pkg::arch_id_t       commit_rd_o,
  output wired_pkg::data_t          commit_data_o
);

  localparam int DEPTH = wired_pkg::ROB_DEPTH;

  wired_pkg::arch_id_t  rd_q   [DEPTH];
  wired_pkg::data_t     data_q [DEPTH];
  logic                 done_q [DEPTH];
  wired_pkg::rob_id_t   head_q;
  wired_pkg::rob_id_t   tail_q;
  logic [wired_pkg::ROB_ID_W:0] count_q; // one extra bit for full

  assign tail_o = tail_q;
  assign full_o = (count_q == DEPTH[wired_pkg::ROB_ID_W:0]);

  // operand reads for dispatch
  always_comb begin
    for (int i = 0; i < 2; i++) begin
      rd_done_o[i] = done_q[rd_id_i[i]];
      rd_data_o[i] = data_q[rd_id_i[i]];
    end
  end

  assign commit_valid_o  = (count_q != '0) && done_q[head_q];
  assign commit_rob_id_o = head_q;
  assign commit_rd_o     = rd_q[head_q];
  assign commit_data_o   = data_q[head_q];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
      for (int e = 0; e < DEPTH; e++) begin
        done_q[e] <= 1'b0;
      end
    end else begin
      if (cdb_valid_i) done_q[cdb_rob_id_i] <= 1'b1;
      if (alloc_i) begin
        done_q[tail_q] <= 1'b0;
        tail_q         <= tail_q + 1'b1;
      end
      if (commit_valid_o) head_q <= head_q + 1'b1;
      case ({alloc_i, commit_valid_o})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (alloc_i) rd_q[tail_q] <= alloc_rd_i;
    if (cdb_valid_i) data_q[cdb_rob_id_i] <= cdb_data_i;
  end

endmodule

`default_nettype wire

// ==== rtl/wired_backend.sv ====
`timescale 1ns/1ps
`default_nettype none

module wired_backend (
  input  wire logic                 clk,
  input  wire logic                 rst_n,
  input  wire logic                 inst_valid_i,
  output logic                      inst_ready_o,
  input  wire wired_pkg::op_t       inst_op_i,
  input  wire wired_pkg::arch_id_t  inst_rd_i,
  input  wire wired_pkg::arch_id_t  inst_rs1_i,
  input  wire wired_pkg::arch_id_t  inst_rs2_i,
  input  wire wired_pkg::data_t     inst_imm_i,
  input  wire logic                 inst_use_imm_i,
  output logic                      commit_valid_o,
  output wired_pkg::arch_id_t       commit_rd_o,
  output wired_pkg::data_t          commit_data_o
);

  // rename stage
  wired_pkg::arch_id_t rf_raddr [2];
  wired_pkg::data_t    rf_rdata [2];
  logic                rob_full, alloc, dispatch_ready, ren_valid;
  wired_pkg::rob_id_t  rob_tail, ren_rob_id, commit_rob_id;
  wired_pkg::op_t      ren_op;
  wired_pkg::arch_id_t ren_rd;
  logic                ren_src_ready  [2];
  wired_pkg::data_t    ren_src_data   [2];
  wired_pkg::rob_id_t  ren_src_rob_id [2];
  // dispatch and execute
  wired_pkg::rob_id_t  rob_rd_id   [2];
  logic                rob_rd_done [2];
  wired_pkg::data_t    rob_rd_data [2];
  logic                alu_busy, alu_valid, mul_valid, alu_req, alu_grant, mul_out_valid;
  wired_pkg::op_t      ex_op;
  wired_pkg::data_t    ex_a, ex_b, alu_data, mul_data;
  wired_pkg::rob_id_t  ex_rob_id, alu_rob_id, mul_rob_id;
  // result bus
  logic                cdb_valid;
  wired_pkg::rob_id_t  cdb_rob_id;
  wired_pkg::data_t    cdb_data;

  wired_rename u_rename (
    .clk, .rst_n, .inst_valid_i, .inst_ready_o, .inst_op_i, .inst_rd_i,
    .inst_rs1_i, .inst_rs2_i, .inst_imm_i, .inst_use_imm_i,
    .rf_raddr_o(rf_raddr), .rf_rdata_i(rf_rdata), .rob_full_i(rob_full),
    .rob_tail_i(rob_tail), .alloc_o(alloc), .dispatch_ready_i(dispatch_ready),
    .ren_valid_o(ren_valid), .ren_op_o(ren_op), .ren_rd_o(ren_rd),
    .ren_rob_id_o(ren_rob_id), .ren_src_ready_o(ren_src_ready),
    .ren_src_data_o(ren_src_data), .ren_src_rob_id_o(ren_src_rob_id),
    .commit_valid_i(commit_valid_o), .commit_rob_id_i(commit_rob_id),
    .commit_rd_i(commit_rd_o)
  );

  wired_regfile u_regfile (
    .clk, .rst_n, .raddr_i(rf_raddr), .rdata_o(rf_rdata),
    .we_i(commit_valid_o), .waddr_i(commit_rd_o), .wdata_i(commit_data_o)
  );

  wired_dispatch u_dispatch (
    .clk, .rst_n, .ren_valid_i(ren_valid), .ren_op_i(ren_op),
    .ren_rob_id_i(ren_rob_id), .ren_src_ready_i(ren_src_ready),
    .ren_src_data_i(ren_src_data), .ren_src_rob_id_i(ren_src_rob_id),
    .dispatch_ready_o(dispatch_ready), .rob_rd_id_o(rob_rd_id),
    .rob_rd_done_i(rob_rd_done), .rob_rd_data_i(rob_rd_data),
    .cdb_valid_i(cdb_valid), .cdb_rob_id_i(cdb_rob_id), .cdb_data_i(cdb_data),
    .alu_busy_i(alu_busy), .alu_valid_o(alu_valid), .mul_valid_o(mul_valid),
    .ex_op_o(ex_op), .ex_a_o(ex_a), .ex_b_o(ex_b), .ex_rob_id_o(ex_rob_id)
  );

  wired_alu u_alu (
    .clk, .rst_n, .valid_i(alu_valid), .op_i(ex_op), .a_i(ex_a), .b_i(ex_b),
    .rob_id_i(ex_rob_id), .busy_o(alu_busy), .req_o(alu_req),
    .grant_i(alu_grant), .rob_id_o(alu_rob_id), .data_o(alu_data)
  );

  wired_muler u_muler (
    .clk, .rst_n, .valid_i(mul_valid), .a_i(ex_a), .b_i(ex_b),
    .rob_id_i(ex_rob_id), .valid_o(mul_out_valid), .rob_id_o(mul_rob_id),
    .data_o(mul_data)
  );

  wired_cdb_arb u_cdb_arb (
    .clk, .rst_n, .alu_req_i(alu_req), .alu_rob_id_i(alu_rob_id),
    .alu_data_i(alu_data), .alu_grant_o(alu_grant), .mul_valid_i(mul_out_valid),
    .mul_rob_id_i(mul_rob_id), .mul_data_i(mul_data), .cdb_valid_o(cdb_valid),
    .cdb_rob_id_o(cdb_rob_id), .cdb_data_o(cdb_data)
  );

  wired_rob u_rob (
    .clk, .rst_n, .alloc_i(alloc), .alloc_rd_i(ren_rd), .tail_o(rob_tail),
    .full_o(rob_full), .rd_id_i(rob_rd_id), .rd_done_o(rob_rd_done),
    .rd_data_o(rob_rd_data), .cdb_valid_i(cdb_valid), .cdb_rob_id_i(cdb_rob_id),
    .cdb_data_i(cdb_data), .commit_valid_o, .commit_rob_id_o(commit_rob_id),
    .commit_rd_o, .commit_data_o
  );

endmodule

`default_nettype wire

// ==== tb/tb_wired_backend.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_wired_backend;

  logic                 clk;
  logic                 rst_n;
  logic                 inst_valid_i;
  logic                 inst_ready_o;
  wired_pkg::op_t       inst_op_i;
  wired_pkg::arch_id_t  inst_rd_i;
  wired_pkg::arch_id_t  inst_rs1_i;
  wired_pkg::arch_id_t  inst_rs2_i;
  wired_pkg::data_t     inst_imm_i;
  logic                 inst_use_imm_i;
  logic                 commit_valid_o;
  wired_pkg::arch_id_t  commit_rd_o;
  wired_pkg::data_t     commit_data_o;

  wired_pkg::data_t     model_regs [wired_pkg::ARCH_REGS];
  wired_pkg::arch_id_t  exp_rd_q [$];
  wired_pkg::data_t     exp_data_q [$];
  logic [31:0]          rng_state;
  int                   err_cnt, err_mark, test_cnt, fail_cnt;
  int                   sent_cnt, stall_cnt, cycle_cnt;

  wired_backend u_dut (
    .clk, .rst_n, .inst_valid_i, .inst_ready_o, .inst_op_i, .inst_rd_i,
    .inst_rs1_i, .inst_rs2_i, .inst_imm_i, .inst_use_imm_i,
    .commit_valid_o, .commit_rd_o, .commit_data_o
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic wired_pkg::data_t compute_expected(input wired_pkg::op_t op,
                                                        input wired_pkg::data_t a,
                                                        input wired_pkg::data_t b);
    case (op)
      wired_pkg::OP_ADD: return a + b;
      wired_pkg::OP_SUB: return a - b;
      wired_pkg::OP_AND: return a & b;
      wired_pkg::OP_OR:  return a | b;
      wired_pkg::OP_XOR: return a ^ b;
      wired_pkg::OP_SLL: return a << b[4:0];
      wired_pkg::OP_MUL: return a * b; // low word of the product
      default:           return '0;
    endcase
  endfunction

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
      err_cnt++;
    end
  endtask

  task automatic check_rd(input wired_pkg::arch_id_t got, input wired_pkg::arch_id_t exp);
    if (got !== exp) begin
      $display("mismatch commit_rd_o: got %h expected %h at %0t", got, exp, $time);
      err_cnt++;
    end
  endtask

  task automatic check_data(input wired_pkg::data_t got, input wired_pkg::data_t exp);
    if (got !== exp) begin
      $display("mismatch commit_data_o: got %h expected %h at %0t", got, exp, $time);
      err_cnt++;
    end
  endtask

  // commits are stable mid-cycle
  always @(negedge clk) begin
    if (rst_n && commit_valid_o) begin
      if (exp_rd_q.size() == 0) begin
        $display("commit of r%0d seen with no instruction outstanding", commit_rd_o);
        err_cnt++;
      end else begin
        check_rd(commit_rd_o, exp_rd_q.pop_front());
        check_data(commit_data_o, exp_data_q.pop_front());
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > 30 * (sent_cnt + 1)) begin
      $display("timeout after %0d cycles with %0d instructions sent", cycle_cnt, sent_cnt);
      $display("TESTS FAILED");
      $finish;
    end
  end

  // model updates in program order before the handshake
  task automatic send_inst(input wired_pkg::op_t op, input wired_pkg::arch_id_t rd,
                           input wired_pkg::arch_id_t rs1, input wired_pkg::arch_id_t rs2,
                           input wired_pkg::data_t imm, input logic use_imm);
    wired_pkg::data_t a;
    wired_pkg::data_t res;
    logic taken;
    a = use_imm ? imm : model_regs[rs1];
    res = compute_expected(op, a, model_regs[rs2]);
    exp_rd_q.push_back(rd);
    exp_data_q.push_back(res);
    if (rd != '0) model_regs[rd] = res;
    sent_cnt++;
    inst_valid_i   = 1'b1;
    inst_op_i      = op;
    inst_rd_i      = rd;
    inst_rs1_i     = rs1;
    inst_rs2_i     = rs2;
    inst_imm_i     = imm;
    inst_use_imm_i = use_imm;
    taken = 1'b0;
    while (!taken) begin
      @(negedge clk);
      taken = inst_ready_o;
      if (!taken) stall_cnt++;
      @(posedge clk);
      #1;
    end
    inst_valid_i = 1'b0;
  endtask

  task automatic send_reg(input wired_pkg::op_t op, input wired_pkg::arch_id_t rd,
                          input wired_pkg::arch_id_t rs1, input wired_pkg::arch_id_t rs2);
    send_inst(op, rd, rs1, rs2, '0, 1'b0);
  endtask

  task automatic send_imm(input wired_pkg::op_t op, input wired_pkg::arch_id_t rd,
                          input wired_pkg::data_t imm, input wired_pkg::arch_id_t rs2);
    send_inst(op, rd, 5'd0, rs2, imm, 1'b1);
  endtask

  task automatic end_test(input string name);
    while (exp_rd_q.size() != 0) @(posedge clk);
    #1;
    test_cnt++;
    if (err_cnt == err_mark) begin
      $display("test %s: ok", name);
    end else begin
      fail_cnt++;
      $display("test %s: %0d errors", name, err_cnt - err_mark);
    end
  endtask

  task automatic test_reset();
    err_mark = err_cnt;
    @(negedge clk);
    check_flag("commit_valid_o", commit_valid_o, 1'b0);
    check_flag("inst_ready_o", inst_ready_o, 1'b1);
    @(posedge clk);
    #1;
    send_imm(wired_pkg::OP_ADD, 5'd1, 32'd5, 5'd0);
    end_test("reset_state");
  endtask

  task automatic test_alu_chain();
    err_mark = err_cnt;
    send_imm(wired_pkg::OP_ADD, 5'd1, 32'd7, 5'd0);
    send_imm(wired_pkg::OP_ADD, 5'd2, 32'd3, 5'd1);
    send_reg(wired_pkg::OP_SUB, 5'd3, 5'd2, 5'd1);
    send_imm(wired_pkg::OP_AND, 5'd4, 32'h0000_00ff, 5'd3);
    send_reg(wired_pkg::OP_OR,  5'd5, 5'd4, 5'd2);
    send_imm(wired_pkg::OP_XOR, 5'd6, 32'h0000_5a5a, 5'd5);
    send_reg(wired_pkg::OP_SLL, 5'd7, 5'd6, 5'd3);
    send_imm(wired_pkg::OP_SLL, 5'd8, 32'd1, 5'd7);
    send_imm(wired_pkg::OP_SUB, 5'd9, 32'hffff_0000, 5'd8);
    end_test("alu_chain");
  endtask

  task automatic test_out_of_order();
    err_mark = err_cnt;
    send_reg(wired_pkg::OP_MUL, 5'd10, 5'd2, 5'd6);
    send_imm(wired_pkg::OP_ADD, 5'd11, 32'd100, 5'd0);
    send_reg(wired_pkg::OP_XOR, 5'd12, 5'd1, 5'd3);
    send_imm(wired_pkg::OP_OR,  5'd13, 32'h10, 5'd4);
    send_reg(wired_pkg::OP_ADD, 5'd14, 5'd10, 5'd11); // needs the product
    send_reg(wired_pkg::OP_MUL, 5'd15, 5'd10, 5'd12);
    end_test("out_of_order");
  endtask

  task automatic test_r0();
    err_mark = err_cnt;
    send_imm(wired_pkg::OP_ADD, 5'd0, 32'h1234, 5'd1);
    send_reg(wired_pkg::OP_ADD, 5'd16, 5'd0, 5'd0);
    send_imm(wired_pkg::OP_OR,  5'd17, 32'd0, 5'd0);
    send_reg(wired_pkg::OP_MUL, 5'd0, 5'd2, 5'd2);
    send_reg(wired_pkg::OP_ADD, 5'd18, 5'd0, 5'd1);
    end_test("r0_writes");
  endtask

  task automatic test_backpressure();
    wired_pkg::arch_id_t prev;
    wired_pkg::arch_id_t dst;
    int stall_mark;
    err_mark = err_cnt;
    stall_mark = stall_cnt;
    prev = 5'd9;
    for (int i = 0; i < 16; i++) begin
      dst = 5'(20 + (i % 4));
      send_reg(wired_pkg::OP_MUL, dst, prev, 5'd3);
      prev = dst;
    end
    if (stall_cnt == stall_mark) begin
      $display("inst_ready_o never went low during the multiply burst");
      err_cnt++;
    end
    end_test("backpressure");
  endtask

  task automatic test_random();
    logic [31:0] r;
    logic [31:0] sel;
    wired_pkg::data_t imm;
    err_mark = err_cnt;
    for (int i = 0; i < 200; i++) begin
      r = next_rand();
      imm = next_rand();
      sel = r % 7;
      // low 16 registers only so dependencies are frequent
      send_inst(wired_pkg::op_t'(sel[2:0]), {1'b0, r[11:8]}, {1'b0, r[15:12]},
                {1'b0, r[19:16]}, imm, r[20]);
    end
    end_test("random_stream");
  endtask

  initial begin
    rng_state = 32'd16795;
    err_cnt = 0;
    err_mark = 0;
    test_cnt = 0;
    fail_cnt = 0;
    sent_cnt = 0;
    stall_cnt = 0;
    cycle_cnt = 0;
    for (int i = 0; i < wired_pkg::ARCH_REGS; i++) begin
      model_regs[i] = '0;
    end
    rst_n          = 1'b0;
    inst_valid_i   = 1'b0;
    inst_op_i      = wired_pkg::OP_ADD;
    inst_rd_i      = '0;
    inst_rs1_i     = '0;
    inst_rs2_i     = '0;
    inst_imm_i     = '0;
    inst_use_imm_i = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;
    test_reset();
    test_alu_chain();
    test_out_of_order();
    test_r0();
    test_backpressure();
    test_random();
    $display("tests run %0d, tests failing %0d, errors %0d", test_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== wired_backend.f ====
rtl/wired_pkg.sv
rtl/wired_regfile.sv
rtl/wired_rename.sv
rtl/wired_dispatch.sv
rtl/wired_alu.sv
rtl/wired_muler.sv
rtl/wired_cdb_arb.sv
rtl/wired_rob.sv
rtl/wired_backend.sv
tb/tb_wired_backend.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the backend testbench with verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps \
  -f wired_backend.f --top-module tb_wired_backend \
  -Mdir "$BUILD_DIR" -o tb_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$BUILD_DIR/tb_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TESTS FAILED" "$LOG"; then
  exit 1
fi
exit 0
